// File: build.f
+incdir+logic
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/dcache_array.sv
logic/dcache_ctrl.sv
logic/retire_buffer.sv
logic/mem_bus_arbiter.sv
logic/dcache_top.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

// File: testbench/dcache_tb.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module dcache_tb import bus_pkg::*; ();

	localparam int SOAK_OPS = 60;
	localparam int TRANSACTIONS = 2 + 3 + 4 + SOAK_OPS;
	localparam int CYCLE_LIMIT = 400 * TRANSACTIONS;

	logic clock;
	logic reset;
	logic proc_req;
	logic proc_store;
	logic [`ADDR_BITS-1:0] proc_addr;
	logic [63:0] proc_wdata;
	logic proc_ack;
	logic [63:0] proc_rdata;
	bus_command_t mem_command;
	logic [`ADDR_BITS-1:0] mem_addr;
	logic [63:0] mem_data;
	mem_tag_t mem_response;
	mem_tag_t mem_tag;
	logic [63:0] mem_rdata;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'h3af3_008a;
	logic [`ADDR_BITS-1:0] ref_addr [$];
	logic [63:0] ref_data [$];

	dcache_top u_dcache_top (
		.clock(clock), .reset(reset),
		.proc_req(proc_req), .proc_store(proc_store), .proc_addr(proc_addr),
		.proc_wdata(proc_wdata), .proc_ack(proc_ack), .proc_rdata(proc_rdata),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_response(mem_response), .mem_tag(mem_tag), .mem_rdata(mem_rdata)
	);

	mem_model u_mem_model (
		.clock(clock), .reset(reset),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_response(mem_response), .mem_tag(mem_tag), .mem_rdata(mem_rdata)
	);

	always #20 clock = ~clock;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'ha300_0000) : (state >> 1);
	endfunction

	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[62:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	function automatic logic [`ADDR_BITS-1:0] line_addr(input logic [`TAG_BITS-1:0] tag,
			input logic [`INDEX_BITS-1:0] idx);
		return {tag, idx, 3'b000};
	endfunction

	// reference memory, same starting contents as the memory model.
	function automatic logic [63:0] ref_read(input logic [`ADDR_BITS-1:0] addr);
		for (int i = 0; i < ref_addr.size(); i++) begin
			if (ref_addr[i] == addr) return ref_data[i];
		end
		return {addr, ~addr};
	endfunction

	function automatic void ref_write(input logic [`ADDR_BITS-1:0] addr, input logic [63:0] data);
		for (int i = 0; i < ref_addr.size(); i++) begin
			if (ref_addr[i] == addr) begin
				ref_data[i] = data;
				return;
			end
		end
		ref_addr.push_back(addr);
		ref_data.push_back(data);
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// one four-phase transaction; edges counts falling edges until ack is seen.
	task automatic run_access(input string name, input logic store,
			input logic [`ADDR_BITS-1:0] addr, input logic [63:0] wdata, output int edges);
		logic [63:0] expected;
		int release_edges;
		expected = store ? wdata : ref_read(addr);
		proc_req = 1'b1;
		proc_store = store;
		proc_addr = addr;
		proc_wdata = wdata;
		edges = 0;
		do begin
			@(negedge clock);
			edges++;
		end while (!proc_ack);
		check_value(name, expected, proc_rdata);
		if (store) ref_write(addr, wdata);
		proc_req = 1'b0;
		release_edges = 0;
		do begin
			@(negedge clock);
			release_edges++;
		end while (proc_ack);
		check_value({name, " ack release"}, 64'd1, release_edges);
	endtask

	task automatic wait_bus_idle();
		int quiet;
		quiet = 0;
		while (quiet < 8) begin
			@(negedge clock);
			quiet = (mem_command == BUS_NONE) ? quiet + 1 : 0;
		end
	endtask

	task automatic check_reset_state();
		repeat (8) begin
			@(negedge clock);
			check_value("reset ack", 64'd0, proc_ack);
			check_value("reset bus", BUS_NONE, mem_command);
		end
		reset = 1'b0;
		@(negedge clock);
		check_value("reset ack", 64'd0, proc_ack);
		check_value("reset bus", BUS_NONE, mem_command);
	endtask

	task automatic read_miss_then_hit();
		int edges;
		run_access("read miss", 1'b0, line_addr(25'h0000012, 4'd1), '0, edges);
		run_access("read hit", 1'b0, line_addr(25'h0000012, 4'd1), '0, edges);
		check_value("hit ack latency", 64'd2, edges - 1); // edges after the one that saw req.
	endtask

	task automatic store_then_load();
		int edges;
		run_access("store", 1'b1, line_addr(25'h0000a5c, 4'd7), 64'h0123_4567_89ab_cdef, edges);
		run_access("load same", 1'b0, line_addr(25'h0000a5c, 4'd7), '0, edges);
		run_access("load neighbor", 1'b0, line_addr(25'h0000a5c, 4'd8), '0, edges);
	endtask

	task automatic eviction_writeback();
		int edges;
		logic [`ADDR_BITS-1:0] first;
		logic [`ADDR_BITS-1:0] second;
		first = line_addr(25'h0000040, 4'd5);
		second = line_addr(25'h0000041, 4'd5);
		run_access("evict store a", 1'b1, first, 64'hdead_0000_beef_0001, edges);
		run_access("evict store b", 1'b1, second, 64'hdead_0000_beef_0002, edges);
		run_access("evict store c", 1'b1, line_addr(25'h0000042, 4'd5),
			64'hdead_0000_beef_0003, edges);
		run_access("evict reload a", 1'b0, first, '0, edges);
		wait_bus_idle();
		check_value("written back a", ref_read(first), u_mem_model.read_word(first));
		check_value("written back b", ref_read(second), u_mem_model.read_word(second));
	endtask

	task automatic backpressure_soak();
		logic [`TAG_BITS-1:0] tags [3];
		logic store;
		logic [1:0] pick;
		logic [`INDEX_BITS-1:0] idx;
		logic [63:0] wdata;
		int edges;
		tags[0] = 25'h0000012;
		tags[1] = 25'h0000a5c;
		tags[2] = 25'h0000040;
		for (int n = 0; n < SOAK_OPS; n++) begin
			store = random_bits(1);
			pick = random_bits(2) % 3;
			idx = random_bits(`INDEX_BITS);
			wdata = store ? random_bits(64) : 64'h0;
			run_access("soak", store, line_addr(tags[pick], idx), wdata, edges);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		proc_req = 1'b0;
		proc_store = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		check_reset_state();
		read_miss_then_hit();
		store_then_load();
		eviction_writeback();
		backpressure_soak();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		errors++;
		$display("ERROR: the run timed out after %0d cycles", cycle_count);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Something failed");
		$finish;
	end

endmodule

// File: testbench/mem_model.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module mem_model import bus_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  bus_command_t          mem_command,
	input  logic [`ADDR_BITS-1:0] mem_addr,
	input  logic [63:0]           mem_data,
	output mem_tag_t              mem_response,
	output mem_tag_t              mem_tag,
	output logic [63:0]           mem_rdata
);

	localparam int LOAD_LATENCY = 6;

	logic [31:0] lfsr = 32'h3af3_008a;
	logic refuse = 1'b1; // nothing is taken before the first draw.
	mem_tag_t next_tag;
	mem_tag_t ret_tag [LOAD_LATENCY];
	logic [63:0] ret_data [LOAD_LATENCY];
	logic [`ADDR_BITS-1:0] written_addr [$];
	logic [63:0] written_data [$];

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'ha300_0000) : (state >> 1);
	endfunction

	// a doubleword never stored holds its address, then the address inverted.
	function automatic logic [63:0] read_word(input logic [`ADDR_BITS-1:0] addr);
		logic [`ADDR_BITS-1:0] line;
		line = {addr[`ADDR_BITS-1:3], 3'b000};
		for (int i = 0; i < written_addr.size(); i++) begin
			if (written_addr[i] == line) return written_data[i];
		end
		return {line, ~line};
	endfunction

	function automatic void write_word(input logic [`ADDR_BITS-1:0] addr, input logic [63:0] data);
		logic [`ADDR_BITS-1:0] line;
		line = {addr[`ADDR_BITS-1:3], 3'b000};
		for (int i = 0; i < written_addr.size(); i++) begin
			if (written_addr[i] == line) begin
				written_data[i] = data;
				return;
			end
		end
		written_addr.push_back(line);
		written_data.push_back(data);
	endfunction

	assign mem_response = (mem_command != BUS_NONE && !refuse) ? next_tag : 4'h0;
	assign mem_tag = ret_tag[LOAD_LATENCY-1];
	assign mem_rdata = ret_data[LOAD_LATENCY-1];

	always @(posedge clock) begin
		refuse <= lfsr[0];
		lfsr <= lfsr_step(lfsr);
		if (reset) begin
			next_tag <= 4'h1;
			for (int i = 0; i < LOAD_LATENCY; i++) ret_tag[i] <= 4'h0;
		end else begin
			for (int i = LOAD_LATENCY - 1; i > 0; i--) begin
				ret_tag[i] <= ret_tag[i-1];
				ret_data[i] <= ret_data[i-1];
			end
			ret_tag[0] <= 4'h0;
			if (mem_response != 4'h0) begin
				next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1; // zero is skipped.
				if (mem_command == BUS_STORE) write_word(mem_addr, mem_data);
				if (mem_command == BUS_LOAD) begin
					ret_tag[0] <= mem_response;
					ret_data[0] <= read_word(mem_addr);
				end
			end
		end
	end

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module dcache_top import bus_pkg::*, cache_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  proc_req,
	input  logic                  proc_store,
	input  logic [`ADDR_BITS-1:0] proc_addr,
	input  logic [63:0]           proc_wdata,
	output logic                  proc_ack,
	output logic [63:0]           proc_rdata,
	output bus_command_t          mem_command,
	output logic [`ADDR_BITS-1:0] mem_addr,
	output logic [63:0]           mem_data,
	input  mem_tag_t              mem_response,
	input  mem_tag_t              mem_tag,
	input  logic [63:0]           mem_rdata
);

	logic [`INDEX_BITS-1:0] rd_idx;
	cache_line_t rd_way0;
	cache_line_t rd_way1;
	logic rd_lru;
	logic wr_en;
	logic wr_way;
	logic [`INDEX_BITS-1:0] wr_idx;
	cache_line_t wr_line;
	logic evict_valid;
	cache_line_t evict_line;
	logic [`INDEX_BITS-1:0] evict_idx;
	logic full;
	mem_addr_t lookup_addr;
	logic lookup_hit;
	logic fill_req;
	mem_addr_t fill_addr;
	logic fill_accept;
	logic fill_valid;
	logic [63:0] fill_data;
	bus_command_t wb_command;
	mem_addr_t wb_addr;
	logic [63:0] wb_data;
	mem_tag_t wb_response;

	dcache_ctrl u_dcache_ctrl (
		.clock(clock), .reset(reset),
		.proc_req(proc_req), .proc_store(proc_store), .proc_addr(proc_addr),
		.proc_wdata(proc_wdata), .proc_ack(proc_ack), .proc_rdata(proc_rdata),
		.rd_idx(rd_idx), .rd_way0(rd_way0), .rd_way1(rd_way1), .rd_lru(rd_lru),
		.wr_en(wr_en), .wr_way(wr_way), .wr_idx(wr_idx), .wr_line(wr_line),
		.evict_valid(evict_valid), .evict_line(evict_line), .evict_idx(evict_idx),
		.full(full), .lookup_addr(lookup_addr), .lookup_hit(lookup_hit),
		.fill_req(fill_req), .fill_addr(fill_addr), .fill_accept(fill_accept),
		.fill_valid(fill_valid), .fill_data(fill_data)
	);

	dcache_array u_dcache_array (
		.clock(clock), .reset(reset),
		.rd_idx(rd_idx), .rd_way0(rd_way0), .rd_way1(rd_way1), .rd_lru(rd_lru),
		.wr_en(wr_en), .wr_way(wr_way), .wr_idx(wr_idx), .wr_line(wr_line)
	);

	retire_buffer u_retire_buffer (
		.clock(clock), .reset(reset),
		.evict_valid(evict_valid), .evict_line(evict_line), .evict_idx(evict_idx),
		.lookup_addr(lookup_addr), .lookup_hit(lookup_hit),
		.wb_command(wb_command), .wb_addr(wb_addr), .wb_data(wb_data),
		.wb_response(wb_response), .full(full)
	);

	mem_bus_arbiter u_mem_bus_arbiter (
		.clock(clock), .reset(reset),
		.fill_req(fill_req), .fill_addr(fill_addr), .fill_accept(fill_accept),
		.fill_valid(fill_valid), .fill_data(fill_data),
		.wb_command(wb_command), .wb_addr(wb_addr), .wb_data(wb_data),
		.wb_response(wb_response),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_response(mem_response), .mem_tag(mem_tag), .mem_rdata(mem_rdata)
	);

endmodule

// File: logic/mem_bus_arbiter.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module mem_bus_arbiter import bus_pkg::*, cache_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fill_req,
	input  mem_addr_t             fill_addr,
	output logic                  fill_accept,
	output logic                  fill_valid,
	output logic [63:0]           fill_data,
	input  bus_command_t          wb_command,
	input  mem_addr_t             wb_addr,
	input  logic [63:0]           wb_data,
	output mem_tag_t              wb_response,
	output bus_command_t          mem_command,
	output logic [`ADDR_BITS-1:0] mem_addr,
	output logic [63:0]           mem_data,
	input  mem_tag_t              mem_response,
	input  mem_tag_t              mem_tag,
	input  logic [63:0]           mem_rdata
);

	logic grant_fill;
	logic load_busy; // a load was accepted and its data is still out.
	mem_tag_t load_tag;

	// fill loads win; only one of them is ever outstanding.
	assign grant_fill = fill_req && !load_busy;

	assign mem_command = grant_fill ? BUS_LOAD : wb_command;
	assign mem_addr = grant_fill ? fill_addr.word : wb_addr.word;
	assign mem_data = grant_fill ? '0 : wb_data;

	assign fill_accept = grant_fill && (mem_response != '0);
	assign wb_response = grant_fill ? '0 : mem_response;

	assign fill_valid = load_busy && (mem_tag == load_tag);
	assign fill_data = mem_rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			load_busy <= 1'b0;
		end else if (fill_accept) begin
			load_busy <= 1'b1;
		end else if (fill_valid) begin
			load_busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_accept) load_tag <= mem_response;
	end

endmodule

// File: logic/retire_buffer.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module retire_buffer import bus_pkg::*, cache_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   evict_valid,
	input  cache_line_t            evict_line,
	input  logic [`INDEX_BITS-1:0] evict_idx,
	input  mem_addr_t              lookup_addr,
	output logic                   lookup_hit,
	output bus_command_t           wb_command,
	output mem_addr_t              wb_addr,
	output logic [63:0]            wb_data,
	input  mem_tag_t               wb_response,
	output logic                   full
);

	localparam int PTR_BITS = $clog2(`RETIRE_SIZE) + 1;

	retire_entry_t queue [`RETIRE_SIZE];
	retire_entry_t queue_next [`RETIRE_SIZE];
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS-1:0] tail_next;
	logic [PTR_BITS-1:0] write_ptr;
	logic send_request; // a store is on the bus.
	logic request_pending;
	logic update_queue;
	logic enqueue;
	mem_addr_t victim_addr;

	assign full = (tail >= PTR_BITS'(`RETIRE_SIZE - 1));

	// only dirty lines need writing back.
	assign enqueue = evict_valid && evict_line.valid && evict_line.dirty && !full;

	assign request_pending = send_request ? (wb_response == '0) : (tail != '0);
	assign update_queue = send_request && (wb_response != '0);

	assign wb_command = send_request ? BUS_STORE : BUS_NONE;
	assign wb_addr = send_request ? queue[0].address : '0;
	assign wb_data = send_request ? queue[0].data : '0;

	always_comb begin
		victim_addr.fields.tag = evict_line.tag;
		victim_addr.fields.idx = evict_idx;
		victim_addr.fields.offset = 3'b0;
	end

	always_comb begin
		lookup_hit = 1'b0;
		for (int i = 0; i < `RETIRE_SIZE; i++) begin
			if (queue[i].valid &&
			    queue[i].address.word[`ADDR_BITS-1:3] == lookup_addr.word[`ADDR_BITS-1:3]) begin
				lookup_hit = 1'b1;
			end
		end
	end

	always_comb begin
		queue_next = queue;
		tail_next = tail;
		write_ptr = tail;
		if (update_queue) begin
			for (int i = 0; i < `RETIRE_SIZE - 1; i++) begin
				queue_next[i] = queue[i + 1];
			end
			queue_next[`RETIRE_SIZE-1].valid = 1'b0;
			tail_next = tail - 1'b1;
			write_ptr = tail - 1'b1; // the new victim lands behind the shifted entries.
		end
		if (enqueue) begin
			queue_next[write_ptr[PTR_BITS-2:0]].valid = 1'b1;
			queue_next[write_ptr[PTR_BITS-2:0]].address = victim_addr;
			queue_next[write_ptr[PTR_BITS-2:0]].data = evict_line.data;
			tail_next = tail_next + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RETIRE_SIZE; i++) begin
				queue[i].valid <= 1'b0;
			end
			tail <= '0;
			send_request <= 1'b0;
		end else begin
			queue <= queue_next;
			tail <= tail_next;
			send_request <= request_pending;
		end
	end

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module dcache_ctrl import cache_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   proc_req,
	input  logic                   proc_store,
	input  mem_addr_t              proc_addr,
	input  logic [63:0]            proc_wdata,
	output logic                   proc_ack,
	output logic [63:0]            proc_rdata,
	output logic [`INDEX_BITS-1:0] rd_idx,
	input  cache_line_t            rd_way0,
	input  cache_line_t            rd_way1,
	input  logic                   rd_lru,
	output logic                   wr_en,
	output logic                   wr_way,
	output logic [`INDEX_BITS-1:0] wr_idx,
	output cache_line_t            wr_line,
	output logic                   evict_valid,
	output cache_line_t            evict_line,
	output logic [`INDEX_BITS-1:0] evict_idx,
	input  logic                   full,
	output mem_addr_t              lookup_addr,
	input  logic                   lookup_hit,
	output logic                   fill_req,
	output mem_addr_t              fill_addr,
	input  logic                   fill_accept,
	input  logic                   fill_valid,
	input  logic [63:0]            fill_data
);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_LOOKUP    = 3'd1;
	localparam logic [2:0] S_EVICT     = 3'd2;
	localparam logic [2:0] S_FILL_REQ  = 3'd3;
	localparam logic [2:0] S_FILL_WAIT = 3'd4;
	localparam logic [2:0] S_RESPOND   = 3'd5;

	logic [2:0] state;
	mem_addr_t req_addr;
	logic req_store;
	logic [63:0] req_wdata;
	logic hit0;
	logic hit1;
	logic hit;
	cache_line_t hit_line;
	logic miss_way;
	logic vic_way;
	cache_line_t vic_line;
	mem_addr_t line_addr;

	// the set is read while idle so that the tags are ready in the lookup state.
	assign rd_idx = (state == S_IDLE) ? proc_addr.fields.idx : req_addr.fields.idx;

	assign hit0 = rd_way0.valid && (rd_way0.tag == req_addr.fields.tag);
	assign hit1 = rd_way1.valid && (rd_way1.tag == req_addr.fields.tag);
	assign hit = hit0 | hit1;
	assign hit_line = hit1 ? rd_way1 : rd_way0;

	// an empty way is used first, otherwise the least recent one.
	assign miss_way = !rd_way0.valid ? 1'b0 : (!rd_way1.valid ? 1'b1 : rd_lru);

	always_comb begin
		line_addr = req_addr;
		line_addr.fields.offset = 3'b0;
	end

	assign lookup_addr = line_addr;
	assign fill_addr = line_addr;
	assign fill_req = (state == S_FILL_REQ) && !lookup_hit; // the old copy must drain first.

	assign evict_valid = (state == S_EVICT) && !full;
	assign evict_line = vic_line;
	assign evict_idx = req_addr.fields.idx;

	always_comb begin
		wr_en = 1'b0;
		wr_way = hit1;
		wr_idx = req_addr.fields.idx;
		wr_line = hit_line;
		if (state == S_LOOKUP && hit) begin
			wr_en = 1'b1; // a load hit is rewritten too, which refreshes the LRU bit.
			if (req_store) begin
				wr_line.dirty = 1'b1;
				wr_line.data = req_wdata;
			end
		end else if (state == S_FILL_WAIT && fill_valid) begin
			wr_en = 1'b1;
			wr_way = vic_way;
			wr_line.valid = 1'b1;
			wr_line.dirty = req_store;
			wr_line.tag = req_addr.fields.tag;
			wr_line.data = req_store ? req_wdata : fill_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			proc_ack <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (proc_req) state <= S_LOOKUP;
				S_LOOKUP: state <= hit ? S_RESPOND : S_EVICT;
				S_EVICT: if (!full) state <= S_FILL_REQ;
				S_FILL_REQ: if (fill_accept) state <= S_FILL_WAIT;
				S_FILL_WAIT: if (fill_valid) state <= S_RESPOND;
				S_RESPOND: begin
					if (!proc_ack) begin
						proc_ack <= 1'b1;
					end else if (!proc_req) begin
						proc_ack <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_IDLE && proc_req) begin
			req_addr <= proc_addr;
			req_store <= proc_store;
			req_wdata <= proc_wdata;
		end
		if (state == S_LOOKUP) begin
			vic_way <= miss_way;
			vic_line <= miss_way ? rd_way1 : rd_way0;
		end
		if (wr_en) proc_rdata <= wr_line.data; // a store answers with its own data.
	end

endmodule

// File: logic/dcache_array.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module dcache_array import cache_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`INDEX_BITS-1:0] rd_idx,
	output cache_line_t            rd_way0,
	output cache_line_t            rd_way1,
	output logic                   rd_lru,
	input  logic                   wr_en,
	input  logic                   wr_way,
	input  logic [`INDEX_BITS-1:0] wr_idx,
	input  cache_line_t            wr_line
);

	cache_line_t lines [2][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] valid [2];
	logic [`CACHE_SETS-1:0] lru; // least recently written way of each set.
	cache_line_t read0;
	cache_line_t read1;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '{default: '0};
			lru <= '0;
		end else if (wr_en) begin
			valid[wr_way][wr_idx] <= wr_line.valid;
			lru[wr_idx] <= ~wr_way; // the way just written becomes most recent.
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			lines[wr_way][wr_idx] <= wr_line;
		end
	end

	// the stored valid field is stale after reset, so it comes from the valid vectors.
	always_comb begin
		read0 = lines[0][rd_idx];
		read0.valid = valid[0][rd_idx];
		read1 = lines[1][rd_idx];
		read1.valid = valid[1][rd_idx];
	end

	always_ff @(posedge clock) begin
		rd_way0 <= read0;
		rd_way1 <= read1;
		rd_lru <= lru[rd_idx];
	end

endmodule

// File: logic/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

	typedef struct packed {
		logic [`TAG_BITS-1:0]   tag;
		logic [`INDEX_BITS-1:0] idx;
		logic [2:0]             offset;
	} addr_fields_t;

	// the bus sees a plain word, the cache splits it into tag, set and offset.
	typedef union packed {
		logic [`ADDR_BITS-1:0] word;
		addr_fields_t          fields;
	} mem_addr_t;

	typedef struct packed {
		logic                 valid;
		logic                 dirty;
		logic [`TAG_BITS-1:0] tag;
		logic [63:0]          data;
	} cache_line_t;

	typedef struct packed {
		logic        valid;
		mem_addr_t   address; // line address of the victim, offset zero.
		logic [63:0] data;
	} retire_entry_t;

endpackage

// File: logic/bus_pkg.sv
package bus_pkg;

	// command on the shared memory bus.
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_t;

	// memory answers a command with a nonzero tag when it takes it.
	// The same tag comes back later with the data of a load.
	typedef logic [3:0] mem_tag_t;

endpackage

// File: logic/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width on the processor port and the memory bus.
`define ADDR_BITS 32

// set index width.
`define INDEX_BITS 4

// number of sets, one per index value.
`define CACHE_SETS 16

// tag width; the low 3 address bits select a byte inside the doubleword line.
`define TAG_BITS (`ADDR_BITS - `INDEX_BITS - 3)

// depth of the write-back queue.
`define RETIRE_SIZE 4

`endif
